// ==== Makefile ====
# Verilator build and run of the texture-mapping front end regression.
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_tmu, fail on a failing log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_tmu -f filelist.f
	-./obj_dir/Vtb_tmu > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
hdl/tmu_pkg.sv
hdl/tmu_adrgen.sv
hdl/tmu_tag_check.sv
hdl/tmu_split.sv
hdl/tmu_frag_release.sv
hdl/tmu_top.sv
sim/tb_tmu.sv

// ==== hdl/tmu_adrgen.sv ====
// Texture width is 2**hres_log2 texels of 16 bits; u is assumed below the width, no wrap or clamp.
`timescale 1ns/1ps

module tmu_adrgen #(
	parameter int hres_log2 = 9
) (
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic stb_i,
	output logic ack_o,
	input  tmu_pkg::point_t point_i,
	input  logic [tmu_pkg::fml_depth-1:0] tex_base_i, // Texture byte base.

	output logic stb_o,
	input  logic ack_i,
	output tmu_pkg::quad_t quad_o,

	output logic busy_o
);

	localparam int aw = tmu_pkg::fml_depth;

	logic [aw-1:0] texel_idx; // Row-major texel number.
	logic [aw-1:0] row_step; // Bytes per texture row.
	logic [aw-1:0] adr_a;
	logic [aw-1:0] adr_c;
	logic valid;
	tmu_pkg::quad_t quad_r;

	// Top-left texel first, the others follow from fixed offsets.
	assign texel_idx = (aw'(point_i.v) << hres_log2) + aw'(point_i.u);
	assign row_step = aw'(2) << hres_log2;
	assign adr_a = tex_base_i + (texel_idx << 1); // Two bytes per texel.
	assign adr_c = adr_a + row_step; // One row down.

	// Register loads whenever it is empty or drained.
	assign ack_o = ~valid | ack_i;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			valid <= 1'b0;
		end else if (ack_o) begin
			valid <= stb_i;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (ack_o) begin
			quad_r.dadr <= point_i.dadr;
			quad_r.tadr[0] <= adr_a;
			quad_r.tadr[1] <= adr_a + aw'(2); // Right neighbour.
			quad_r.tadr[2] <= adr_c;
			quad_r.tadr[3] <= adr_c + aw'(2);
			quad_r.x_frac <= point_i.x_frac;
			quad_r.y_frac <= point_i.y_frac;
		end
	end

	assign stb_o = valid;
	assign quad_o = quad_r;
	assign busy_o = valid;

	// Quad must not change under a stalled strobe.
	a_quad_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
		stb_o && !ack_i |=> $stable(quad_o));

endmodule

// ==== hdl/tmu_frag_release.sv ====
// Completions must arrive in request order, one pulse per accepted fetch; fifo_depth_log2 is at least 1.
`timescale 1ns/1ps

module tmu_frag_release #(
	parameter int fifo_depth_log2 = 4
) (
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic stb_i,
	output logic ack_o,
	input  tmu_pkg::frag_t frag_i,
	input  logic has_miss_i, // Fragment waits on a fetch.

	input  logic fetch_done_i, // One pulse per burst done.

	output logic stb_o,
	input  logic ack_i,
	output tmu_pkg::frag_t frag_o,

	output logic busy_o
);

	localparam int depth = 1 << fifo_depth_log2;
	localparam int cw = fifo_depth_log2 + 1; // Counts up to depth.
	localparam int sw = cw + 1;

	tmu_pkg::frag_t frag_mem [depth];
	logic [depth-1:0] miss_mem; // Per slot has_miss flag.
	logic [cw-1:0] wr_ptr; // Extra bit tells full from empty.
	logic [cw-1:0] rd_ptr;
	logic [cw-1:0] count;
	logic [cw-1:0] credit; // Completions not yet consumed.
	logic [sw-1:0] credit_sum;
	logic empty;
	logic full;
	logic push;
	logic pop;
	logic head_miss;
	logic pop_miss;

	assign count = wr_ptr - rd_ptr;
	assign empty = (count == '0);
	assign full = count[fifo_depth_log2];

	assign ack_o = ~full;
	assign push = stb_i & ~full;

	assign head_miss = miss_mem[rd_ptr[fifo_depth_log2-1:0]];
	assign frag_o = frag_mem[rd_ptr[fifo_depth_log2-1:0]];

	// Head goes out when it is a hit or its fetch is done.
	assign stb_o = ~empty & (~head_miss | (credit != '0));
	assign pop = stb_o & ack_i;
	assign pop_miss = pop & head_miss;

	// Widened so a wrap shows up in the top bit.
	assign credit_sum = {1'b0, credit} + sw'(fetch_done_i) - sw'(pop_miss);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			credit <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			credit <= credit_sum[cw-1:0];
		end
	end

	always_ff @(posedge sys_clk) begin
		if (push) begin
			frag_mem[wr_ptr[fifo_depth_log2-1:0]] <= frag_i;
			miss_mem[wr_ptr[fifo_depth_log2-1:0]] <= has_miss_i;
		end
	end

	// Outstanding work always sits behind a queued fragment.
	assign busy_o = ~empty;

	// Credit stays in range and never outruns the queued fragments.
	a_credit: assert property (@(posedge sys_clk) disable iff (sys_rst)
		!credit_sum[cw] && credit <= count);

endmodule

// ==== hdl/tmu_pkg.sv ====
// Fixed memory map: 26-bit byte addresses, 8 KB direct-mapped texel cache, 32-byte bursts, 16-bit texels.
package tmu_pkg;

	localparam int fml_depth = 26; // Memory byte address width.
	localparam int cache_depth = 13; // Log2 of texel cache bytes.
	localparam int line_log2 = 5; // 32-byte burst line.
	localparam int frac_w = 6; // Bilinear fraction.
	localparam int idx_w = cache_depth - line_log2; // Tag store index width.
	localparam int tag_w = fml_depth - cache_depth; // Address bits above the cache.
	localparam int line_cnt = 1 << idx_w; // Lines in the tag store.
	localparam int burst_w = fml_depth - line_log2; // Burst address width.

	// Input point as delivered by the rasterizer.
	typedef struct packed {
		logic [fml_depth-2:0] dadr; // Destination pixel, 16-bit word address.
		logic [10:0] u; // Integer texel column.
		logic [10:0] v; // Integer texel row.
		logic [frac_w-1:0] x_frac;
		logic [frac_w-1:0] y_frac;
	} point_t;

	// Bilinear quad, texels ordered a, b, c, d.
	typedef struct packed {
		logic [fml_depth-2:0] dadr;
		logic [3:0][fml_depth-1:0] tadr; // Byte addresses, index 0 is a.
		logic [frac_w-1:0] x_frac;
		logic [frac_w-1:0] y_frac;
	} quad_t;

	typedef struct packed {
		quad_t quad;
		logic [3:0] miss; // Per texel cache miss.
	} checked_t;

	// Fragment handed to the filter side.
	typedef struct packed {
		logic [fml_depth-2:0] dadr;
		logic [3:0][cache_depth-1:0] tadr; // Cache-local byte addresses.
		logic [frac_w-1:0] x_frac;
		logic [frac_w-1:0] y_frac;
		logic [3:0] miss;
	} frag_t;

	typedef struct packed {
		logic [3:0][burst_w-1:0] tadr; // Burst line addresses.
		logic [3:0] miss; // Only these lines are fetched.
	} fetch_t;

endpackage

// ==== hdl/tmu_split.sv ====
// Fragment and fetch sides move together; a quad never leaves on one side without the other.
`timescale 1ns/1ps

module tmu_split (
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic stb_i,
	output logic ack_o,
	input  tmu_pkg::checked_t checked_i,

	output logic frag_stb_o,
	input  logic frag_ack_i,
	output tmu_pkg::frag_t frag_o,

	output logic fetch_stb_o,
	input  logic fetch_ack_i,
	output tmu_pkg::fetch_t fetch_o,

	output logic has_miss_o, // Current quad needs a fetch.
	output logic busy_o
);

	logic valid;
	logic advance;
	tmu_pkg::checked_t r; // Shared by both views.

	assign advance = frag_ack_i & fetch_ack_i; // Joint acknowledge.
	assign ack_o = ~valid | advance;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			valid <= 1'b0;
		end else if (ack_o) begin
			valid <= stb_i;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (ack_o) begin
			r <= checked_i;
		end
	end

	assign has_miss_o = |r.miss;

	// Each strobe is offered only when the other side is ready too.
	assign frag_stb_o = valid & fetch_ack_i;
	assign fetch_stb_o = valid & has_miss_o & frag_ack_i; // Hits need no fetch.

	// Low bits index the cache, high bits name the burst.
	always_comb begin
		frag_o.dadr = r.quad.dadr;
		frag_o.x_frac = r.quad.x_frac;
		frag_o.y_frac = r.quad.y_frac;
		frag_o.miss = r.miss;
		fetch_o.miss = r.miss;
		for (int i = 0; i < 4; i++) begin
			frag_o.tadr[i] = r.quad.tadr[i][tmu_pkg::cache_depth-1:0];
			fetch_o.tadr[i] = r.quad.tadr[i][tmu_pkg::fml_depth-1:tmu_pkg::line_log2];
		end
	end

	assign busy_o = valid;

	// Upstream keeps its checked quad steady until this stage takes it.
	a_input_held: assert property (@(posedge sys_clk) disable iff (sys_rst)
		stb_i && !ack_o |=> stb_i && $stable(checked_i));

endmodule

// ==== hdl/tmu_tag_check.sv ====
// Tags only, no data RAM; all missing lines are marked valid at once, as if the fetch already landed.
`timescale 1ns/1ps

module tmu_tag_check (
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic stb_i,
	output logic ack_o,
	input  tmu_pkg::quad_t quad_i,

	output logic stb_o,
	input  logic ack_i,
	output tmu_pkg::checked_t checked_o,

	output logic busy_o
);

	logic [tmu_pkg::line_cnt-1:0] tag_vld; // Line valid bits.
	logic [tmu_pkg::tag_w-1:0] tag_mem [tmu_pkg::line_cnt];
	logic [3:0][tmu_pkg::idx_w-1:0] idx;
	logic [3:0][tmu_pkg::tag_w-1:0] tag;
	logic [3:0] miss;
	logic accept;
	logic valid;
	tmu_pkg::checked_t checked_r;

	// Lookup against the store as it was before this quad.
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			idx[i] = quad_i.tadr[i][tmu_pkg::cache_depth-1:tmu_pkg::line_log2];
			tag[i] = quad_i.tadr[i][tmu_pkg::fml_depth-1:tmu_pkg::cache_depth];
			miss[i] = ~tag_vld[idx[i]] | (tag_mem[idx[i]] != tag[i]);
		end
	end

	assign ack_o = ~valid | ack_i;
	assign accept = stb_i & ack_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			tag_vld <= '0; // Cold cache.
		end else if (accept) begin
			for (int i = 0; i < 4; i++) begin
				if (miss[i]) begin
					tag_vld[idx[i]] <= 1'b1;
				end
			end
		end
	end

	// Loop order a to d, so the last texel on a shared index wins.
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			for (int i = 0; i < 4; i++) begin
				if (miss[i]) begin
					tag_mem[idx[i]] <= tag[i];
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			valid <= 1'b0;
		end else if (ack_o) begin
			valid <= stb_i;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (ack_o) begin
			checked_r.quad <= quad_i;
			checked_r.miss <= miss; // Flags travel with the quad.
		end
	end

	assign stb_o = valid;
	assign checked_o = checked_r;
	assign busy_o = valid;

	// Texel d always owns its line for the next lookup.
	a_last_wins: assert property (@(posedge sys_clk) disable iff (sys_rst)
		accept |=> tag_vld[$past(idx[3])] && tag_mem[$past(idx[3])] == $past(tag[3]));

endmodule

// ==== hdl/tmu_top.sv ====
// Fetch engine and cache data RAM are external; fetch_done_i must follow accepted requests in order.
`timescale 1ns/1ps

module tmu_top #(
	parameter int hres_log2 = 9, // Texture width log2.
	parameter int fifo_depth_log2 = 4
) (
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic [tmu_pkg::fml_depth-1:0] tex_base_i,

	input  logic point_stb_i,
	output logic point_ack_o,
	input  tmu_pkg::point_t point_i,

	output logic fetch_stb_o,
	input  logic fetch_ack_i,
	output tmu_pkg::fetch_t fetch_o,
	input  logic fetch_done_i,

	output logic frag_stb_o,
	input  logic frag_ack_i,
	output tmu_pkg::frag_t frag_o,

	output logic busy_o
);

	logic quad_stb;
	logic quad_ack;
	tmu_pkg::quad_t quad;
	logic chk_stb;
	logic chk_ack;
	tmu_pkg::checked_t checked;
	logic split_stb; // Split to release FIFO.
	logic split_ack;
	tmu_pkg::frag_t split_frag;
	logic split_has_miss;
	logic adrgen_busy;
	logic tag_busy;
	logic split_busy;
	logic release_busy;

	tmu_adrgen #(
		.hres_log2(hres_log2)
	) u_adrgen (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.stb_i(point_stb_i),
		.ack_o(point_ack_o),
		.point_i(point_i),
		.tex_base_i(tex_base_i),
		.stb_o(quad_stb),
		.ack_i(quad_ack),
		.quad_o(quad),
		.busy_o(adrgen_busy)
	);

	tmu_tag_check u_tag_check (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.stb_i(quad_stb),
		.ack_o(quad_ack),
		.quad_i(quad),
		.stb_o(chk_stb),
		.ack_i(chk_ack),
		.checked_o(checked),
		.busy_o(tag_busy)
	);

	tmu_split u_split (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.stb_i(chk_stb),
		.ack_o(chk_ack),
		.checked_i(checked),
		.frag_stb_o(split_stb),
		.frag_ack_i(split_ack),
		.frag_o(split_frag),
		.fetch_stb_o(fetch_stb_o),
		.fetch_ack_i(fetch_ack_i),
		.fetch_o(fetch_o),
		.has_miss_o(split_has_miss),
		.busy_o(split_busy)
	);

	tmu_frag_release #(
		.fifo_depth_log2(fifo_depth_log2)
	) u_frag_release (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.stb_i(split_stb),
		.ack_o(split_ack),
		.frag_i(split_frag),
		.has_miss_i(split_has_miss),
		.fetch_done_i(fetch_done_i),
		.stb_o(frag_stb_o),
		.ack_i(frag_ack_i),
		.frag_o(frag_o),
		.busy_o(release_busy)
	);

	// Release FIFO also covers fetches in flight.
	assign busy_o = adrgen_busy | tag_busy | split_busy | release_busy;

endmodule

// ==== sim/tb_tmu.sv ====
// Texture width fixed at 16 texels; three texture bases 8 KB apart force tag conflicts; completions return in order.
`timescale 1ns/1ps

module tb_tmu;

	localparam int hres_log2 = 4;
	localparam int fifo_depth_log2 = 2;
	localparam int n_points = 300;
	localparam int cycle_limit = n_points * 40; // Generous per-point budget.
	localparam int aw = tmu_pkg::fml_depth;
	localparam int dw = tmu_pkg::fml_depth - 1;
	localparam int bw = tmu_pkg::burst_w;

	logic sys_clk;
	logic sys_rst;
	logic [aw-1:0] tex_base_i;
	logic point_stb_i;
	logic point_ack_o;
	tmu_pkg::point_t point_i;
	logic fetch_stb_o;
	logic fetch_ack_i;
	tmu_pkg::fetch_t fetch_o;
	logic fetch_done_i;
	logic frag_stb_o;
	logic frag_ack_i;
	tmu_pkg::frag_t frag_o;
	logic busy_o;

	logic [tmu_pkg::line_cnt-1:0] model_vld; // Model tag store.
	logic [tmu_pkg::tag_w-1:0] model_tag [tmu_pkg::line_cnt];
	tmu_pkg::frag_t exp_frag [$]; // Expected fragments, point order.
	tmu_pkg::fetch_t exp_fetch [$];
	int unsigned done_delay [$]; // Cycles left per accepted request.
	int points_sent;
	int fetches_seen;
	int miss_frags_out; // Missing fragments released so far.
	int dones_taken; // Completions already sampled by the DUT.
	int cycles;
	bit point_taken;
	bit running;

	tmu_top #(
		.hres_log2(hres_log2),
		.fifo_depth_log2(fifo_depth_log2)
	) DUT (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.tex_base_i(tex_base_i),
		.point_stb_i(point_stb_i),
		.point_ack_o(point_ack_o),
		.point_i(point_i),
		.fetch_stb_o(fetch_stb_o),
		.fetch_ack_i(fetch_ack_i),
		.fetch_o(fetch_o),
		.fetch_done_i(fetch_done_i),
		.frag_stb_o(frag_stb_o),
		.frag_ack_i(frag_ack_i),
		.frag_o(frag_o),
		.busy_o(busy_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk; // 100 ns period.
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_frag(input string name, input tmu_pkg::frag_t exp,
		input tmu_pkg::frag_t act);
		if (act !== exp) begin
			abort_run($sformatf("error %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_fetch(input string name, input tmu_pkg::fetch_t exp,
		input tmu_pkg::fetch_t act);
		if (act !== exp) begin
			abort_run($sformatf("error %s expected %h actual %h", name, exp, act));
		end
	endtask

	// Bilinear quad from the address rule, lookup before any update.
	task automatic model_point(input tmu_pkg::point_t p, input logic [aw-1:0] base);
		logic [aw-1:0] adr [4];
		logic [tmu_pkg::idx_w-1:0] ix;
		logic [tmu_pkg::tag_w-1:0] tg;
		tmu_pkg::frag_t f;
		tmu_pkg::fetch_t q;
		int width;
		width = 1 << hres_log2;
		adr[0] = base + aw'(2 * (int'(p.v) * width + int'(p.u)));
		adr[1] = adr[0] + aw'(2);
		adr[2] = adr[0] + aw'(2 * width); // One texture row down.
		adr[3] = adr[2] + aw'(2);
		f.dadr = p.dadr;
		f.x_frac = p.x_frac;
		f.y_frac = p.y_frac;
		for (int i = 0; i < 4; i++) begin
			ix = adr[i][tmu_pkg::cache_depth-1:tmu_pkg::line_log2];
			tg = adr[i][aw-1:tmu_pkg::cache_depth];
			f.miss[i] = !model_vld[ix] || (model_tag[ix] != tg);
			f.tadr[i] = adr[i][tmu_pkg::cache_depth-1:0];
			q.tadr[i] = bw'(adr[i] >> tmu_pkg::line_log2);
		end
		q.miss = f.miss;
		// Order a to d, later texel owns a shared line.
		for (int i = 0; i < 4; i++) begin
			ix = adr[i][tmu_pkg::cache_depth-1:tmu_pkg::line_log2];
			if (f.miss[i]) begin
				model_vld[ix] = 1'b1;
				model_tag[ix] = adr[i][aw-1:tmu_pkg::cache_depth];
			end
		end
		exp_frag.push_back(f);
		if (|f.miss) begin
			exp_fetch.push_back(q); // Hits send no request.
		end
	endtask

	// In-order responder, one pulse when the head delay runs out.
	task automatic drive_completion();
		fetch_done_i = 1'b0;
		if (done_delay.size() != 0) begin
			if (done_delay[0] == 0) begin
				fetch_done_i = 1'b1;
				void'(done_delay.pop_front());
			end else begin
				done_delay[0] = done_delay[0] - 1;
			end
		end
	endtask

	// Inputs for the coming cycle.
	task automatic next_cycle();
		cycles++;
		if (cycles > cycle_limit) begin
			abort_run($sformatf("timeout after %0d cycles with %0d of %0d points accepted",
				cycles, points_sent, n_points));
		end else begin
			if (fetch_done_i) begin
				dones_taken++; // Pulse was sampled at this edge.
			end
			drive_completion();
			frag_ack_i = ($urandom_range(3) != 0); // Random back-pressure.
			fetch_ack_i = ($urandom_range(2) != 0);
			if (point_taken) begin
				point_stb_i = 1'b0;
				point_taken = 1'b0;
			end
			if (!point_stb_i && points_sent < n_points && $urandom_range(3) != 0) begin
				point_i.dadr = dw'($urandom);
				point_i.u = 11'($urandom_range(15));
				point_i.v = 11'($urandom_range(23)); // Few rows, lines repeat.
				point_i.x_frac = 6'($urandom_range(63));
				point_i.y_frac = 6'($urandom_range(63));
				tex_base_i = (aw'($urandom_range(2)) << tmu_pkg::cache_depth)
					+ aw'(64 * $urandom_range(3));
				point_stb_i = 1'b1;
			end
		end
	endtask

	// Sampled mid-cycle, transfers land on the next rising edge.
	task automatic observe_outputs();
		tmu_pkg::frag_t ef;
		tmu_pkg::fetch_t eq;
		if (point_stb_i && point_ack_o) begin
			model_point(point_i, tex_base_i);
			points_sent++;
			point_taken = 1'b1;
		end
		if (fetch_stb_o && fetch_ack_i) begin
			if (exp_fetch.size() == 0) begin
				abort_run("fetch request issued for a quad without a miss");
			end else begin
				eq = exp_fetch.pop_front();
				check_fetch($sformatf("fetch request %0d", fetches_seen), eq, fetch_o);
				fetches_seen++;
				done_delay.push_back($urandom_range(6));
			end
		end
		if (frag_stb_o && frag_ack_i) begin
			if (exp_frag.size() == 0) begin
				abort_run("fragment released with none outstanding");
			end else begin
				ef = exp_frag.pop_front();
				check_frag("fragment address and miss", ef, frag_o);
				if (|ef.miss) begin
					miss_frags_out++;
					if (miss_frags_out > dones_taken) begin
						abort_run("fragment with a miss released before its fetch completed");
					end
				end
			end
		end
	endtask

	initial begin
		void'($urandom(11)); // Single seed for the whole run.
		sys_rst = 1'b1;
		tex_base_i = '0;
		point_stb_i = 1'b0;
		point_i = '0;
		fetch_ack_i = 1'b0;
		fetch_done_i = 1'b0;
		frag_ack_i = 1'b0;
		model_vld = '0;
		points_sent = 0;
		fetches_seen = 0;
		miss_frags_out = 0;
		dones_taken = 0;
		cycles = 0;
		point_taken = 1'b0;
		repeat (3) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		running = 1'b1;
		while (running) begin
			@(negedge sys_clk);
			observe_outputs();
			running = points_sent < n_points || exp_frag.size() != 0 || done_delay.size() != 0;
			@(posedge sys_clk);
			#1;
			next_cycle();
		end
		// Drain until every stage reports idle.
		@(negedge sys_clk);
		while (busy_o) begin
			@(posedge sys_clk);
			#1;
			next_cycle();
			@(negedge sys_clk);
			observe_outputs();
		end
		if (frag_stb_o || fetch_stb_o) begin
			abort_run("a strobe output stays high after the pipeline drained");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule
